// ==== uart_pkg.sv ====
`default_nettype none

package uart_pkg;

    // one queued byte plus its stop bit choice
    typedef struct packed {
        logic [7:0] data;     // byte to send, lsb goes out first
        logic       two_stop; // high selects two stop bits
    } tx_frame_t;

    // framer line states, data bits share one state with an index
    typedef enum logic [2:0] {
        IDLE,   // line high, waiting for a frame
        START,  // start bit, line low
        DATA,   // eight data bits
        PARITY, // even parity bit
        STOP1,  // first stop bit
        STOP2   // optional second stop bit
    } framer_state_t;

endpackage

`default_nettype wire

// ==== tx_frame_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_frame_fifo
    import uart_pkg::*;
#(
    parameter int FIFO_DEPTH = 4 // power of two
) (
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire logic      in_valid,
    input  wire tx_frame_t in_frame,
    output logic           in_ready,
    output logic           out_valid,
    output tx_frame_t      out_frame,
    input  wire logic      out_ready
);

    localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    tx_frame_t         mem [FIFO_DEPTH]; // frame storage
    logic [AW-1:0]     wr_ptr;
    logic [AW-1:0]     rd_ptr;
    logic [CW-1:0]     count;            // number of frames held
    logic              push;
    logic              pop;

    assign in_ready  = (count != CW'(FIFO_DEPTH));
    assign out_valid = (count != '0);
    assign out_frame = mem[rd_ptr];      // head entry

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_frame;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1; // wraps at the power-of-two depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // none, or push and pop together
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== tx_rr_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_rr_arbiter
    import uart_pkg::*;
#(
    parameter int NUM_CLIENTS = 4
) (
    input  wire logic                        clk,
    input  wire logic                        reset,
    input  wire logic [NUM_CLIENTS-1:0]      req_valid,
    input  wire tx_frame_t [NUM_CLIENTS-1:0] req_frame,
    output logic [NUM_CLIENTS-1:0]           req_ready,
    output logic                             frame_valid,
    output tx_frame_t                        frame,
    input  wire logic                        frame_ready
);

    localparam int PW = (NUM_CLIENTS > 1) ? $clog2(NUM_CLIENTS) : 1;

    logic [PW-1:0] ptr;         // first index to look at
    logic [PW-1:0] grant_idx;
    logic          grant_found;
    int            scan_idx;
    logic          xfer;

    // walk the requests once, starting at the pointer and wrapping around
    always_comb begin
        grant_found = 1'b0;
        grant_idx   = '0;
        scan_idx    = 0;
        for (int i = 0; i < NUM_CLIENTS; i++) begin
            scan_idx = (int'(ptr) + i) % NUM_CLIENTS;
            if (!grant_found && req_valid[scan_idx]) begin
                grant_found = 1'b1;
                grant_idx   = PW'(scan_idx);
            end
        end
    end

    assign frame_valid = grant_found;
    assign frame       = req_frame[grant_idx];  // mux of the granted head
    assign xfer        = frame_valid && frame_ready;

    // only the granted fifo sees ready, and only while the framer takes it
    always_comb begin
        req_ready = '0;
        if (frame_ready && grant_found) begin
            req_ready[grant_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= '0;
        end else if (xfer) begin
            if (grant_idx == PW'(NUM_CLIENTS - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= grant_idx + 1'b1; // next in line gets first look
            end
        end
    end

endmodule

`default_nettype wire

// ==== uart_tx_framer.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx_framer
    import uart_pkg::*;
#(
    parameter int CLKS_PER_BIT = 4
) (
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire logic      frame_valid,
    input  wire tx_frame_t frame,
    output logic           frame_ready,
    output logic           tx,
    output logic           busy,
    output logic           frame_done
);

    localparam int CW = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    framer_state_t state;
    tx_frame_t     frame_q;  // frame being sent
    logic [CW-1:0] clk_cnt;  // cycles spent in the current bit
    logic [2:0]    bit_idx;  // data bit on the line
    logic          bit_end;
    logic          parity;
    logic          last_stop;

    assign bit_end     = (clk_cnt == CW'(CLKS_PER_BIT - 1));
    assign parity      = ^frame_q.data; // even parity
    assign last_stop   = (state == STOP2) || (state == STOP1 && !frame_q.two_stop);
    assign frame_ready = (state == IDLE);
    assign busy        = (state != IDLE);
    assign frame_done  = last_stop && bit_end;

    always_ff @(posedge clk) begin
        if (frame_valid && frame_ready) begin
            frame_q <= frame;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            tx      <= 1'b1; // line idles high
        end else begin
            if (state == IDLE || bit_end) begin
                clk_cnt <= '0;
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end

            case (state)
                IDLE: begin
                    if (frame_valid) begin
                        state   <= START;
                        bit_idx <= '0;
                        tx      <= 1'b0; // start bit from the next cycle
                    end
                end
                START: begin
                    if (bit_end) begin
                        state <= DATA;
                        tx    <= frame_q.data[0];
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            state <= PARITY;
                            tx    <= parity;
                        end else begin
                            bit_idx <= bit_idx + 3'd1;
                            tx      <= frame_q.data[bit_idx + 3'd1];
                        end
                    end
                end
                PARITY: begin
                    if (bit_end) begin
                        state <= STOP1;
                        tx    <= 1'b1;
                    end
                end
                STOP1: begin
                    if (bit_end) begin
                        state <= frame_q.two_stop ? STOP2 : IDLE;
                    end
                end
                STOP2: begin
                    if (bit_end) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                    tx    <= 1'b1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== uart_tx_hub.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx_hub
    import uart_pkg::*;
#(
    parameter int NUM_CLIENTS  = 4,
    parameter int FIFO_DEPTH   = 4,
    parameter int CLKS_PER_BIT = 4
) (
    input  wire logic                        clk,
    input  wire logic                        reset,
    input  wire logic [NUM_CLIENTS-1:0]      client_valid,
    input  wire tx_frame_t [NUM_CLIENTS-1:0] client_frame,
    output logic [NUM_CLIENTS-1:0]           client_ready,
    output logic                             tx,
    output logic                             busy,
    output logic                             frame_done
);

    logic [NUM_CLIENTS-1:0]      fifo_valid;
    logic [NUM_CLIENTS-1:0]      fifo_ready;
    tx_frame_t [NUM_CLIENTS-1:0] fifo_frame;
    logic                        frame_valid;
    logic                        frame_ready;
    tx_frame_t                   frame;

    // one frame queue per client
    for (genvar k = 0; k < NUM_CLIENTS; k++) begin : g_fifo
        tx_frame_fifo #(
            .FIFO_DEPTH(FIFO_DEPTH)
        ) fifo_i (
            .clk       (clk),
            .reset     (reset),
            .in_valid  (client_valid[k]),
            .in_frame  (client_frame[k]),
            .in_ready  (client_ready[k]),
            .out_valid (fifo_valid[k]),
            .out_frame (fifo_frame[k]),
            .out_ready (fifo_ready[k])
        );
    end

    tx_rr_arbiter #(
        .NUM_CLIENTS(NUM_CLIENTS)
    ) arbiter_i (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (fifo_valid),
        .req_frame   (fifo_frame),
        .req_ready   (fifo_ready),
        .frame_valid (frame_valid),
        .frame       (frame),
        .frame_ready (frame_ready)
    );

    uart_tx_framer #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) framer_i (
        .clk         (clk),
        .reset       (reset),
        .frame_valid (frame_valid),
        .frame       (frame),
        .frame_ready (frame_ready),
        .tx          (tx),
        .busy        (busy),
        .frame_done  (frame_done)
    );

endmodule

`default_nettype wire

// ==== tb_uart_tx_hub.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_uart_tx_hub
    import uart_pkg::*;
;

    localparam int NUM_CLIENTS  = 4;
    localparam int CLKS_PER_BIT = 4;
    localparam int CLK_PERIOD   = 8;
    localparam int TOTAL_FRAMES = 1 + 4 + 32 + 10; // frames pushed over all tests
    localparam int MAX_SAMPLES  = 13 * CLKS_PER_BIT; // two stop bits plus one spare bit period

    logic                        clk;
    logic                        reset;
    logic [NUM_CLIENTS-1:0]      client_valid;
    tx_frame_t [NUM_CLIENTS-1:0] client_frame;
    logic [NUM_CLIENTS-1:0]      client_ready;
    logic                        tx;
    logic                        busy;
    logic                        frame_done;

    tx_frame_t              sent_q [NUM_CLIENTS][$]; // frames each client handed over
    logic                   line_s [MAX_SAMPLES];    // tx sampled once per clock
    int                     n_samp;
    int                     seed = 19;
    int                     errors;
    int                     failed_tests;
    int                     push_count;
    int                     rx_count;
    int                     done_cnt;
    int                     last_client;
    logic                   rot_check;
    logic [NUM_CLIENTS-1:0] full_seen;                // client saw ready low while waiting

    uart_tx_hub uart_tx_hub_i (
        .clk          (clk),
        .reset        (reset),
        .client_valid (client_valid),
        .client_frame (client_frame),
        .client_ready (client_ready),
        .tx           (tx),
        .busy         (busy),
        .frame_done   (frame_done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // start 0, data lsb first, even parity, then one or two stop bits
    function automatic logic [11:0] expected_line(input tx_frame_t f, output int len);
        logic [11:0] bits;
        bits[0] = 1'b0;
        for (int i = 0; i < 8; i++) begin
            bits[i + 1] = f.data[i];
        end
        bits[9]  = ^f.data;
        bits[10] = 1'b1;
        bits[11] = 1'b1;
        len = f.two_stop ? 12 : 11;
        return bits;
    endfunction

    task automatic report_mismatch(input string name, input int exp, input int got);
        $display("MISMATCH at %0t ns: %s expected 0x%0h got 0x%0h", $time, name, exp, got);
        errors++;
    endtask

    task automatic push_frame(input int c, input tx_frame_t f);
        client_valid[c] = 1'b1;
        client_frame[c] = f;
        while (!client_ready[c]) begin
            full_seen[c] = 1'b1;
            @(negedge clk);
        end
        sent_q[c].push_back(f);
        push_count++;
        @(negedge clk); // transfer happened on the edge in between
        client_valid[c] = 1'b0;
    endtask

    task automatic push_burst(input int c, input int n);
        logic [31:0] rnd;
        tx_frame_t   f;
        for (int i = 0; i < n; i++) begin
            rnd        = $random(seed);
            f.data     = {2'(c), rnd[5:0]}; // client index rides in the top bits
            f.two_stop = rnd[6];
            push_frame(c, f);
        end
    endtask

    task automatic wait_drain();
        wait (rx_count == push_count);
        @(negedge clk);
    endtask

    task automatic end_test(input string name, input int errors_before);
        if (errors != errors_before) begin
            failed_tests++;
        end
        $display("test %s finished with %0d errors", name, errors - errors_before);
    endtask

    task automatic check_frame();
        logic [7:0]  rx_data;
        logic [11:0] bits;
        tx_frame_t   exp_f;
        int          client;
        int          len;
        logic        bad;
        for (int i = 0; i < 8; i++) begin
            rx_data[i] = line_s[(i + 1) * CLKS_PER_BIT + CLKS_PER_BIT / 2];
        end
        client = int'(rx_data[7:6]);
        rx_count++;
        assert (sent_q[client].size() > 0) else begin
            $display("frame 0x%0h arrived at %0t ns but client %0d had nothing queued",
                     rx_data, $time, client);
            errors++;
        end
        if (sent_q[client].size() > 0) begin
            exp_f = sent_q[client].pop_front();
            bits  = expected_line(exp_f, len);
            assert (rx_data == exp_f.data) else report_mismatch("tx data", exp_f.data, rx_data);
            assert (n_samp == len * CLKS_PER_BIT)
                else report_mismatch("frame_done cycle", len * CLKS_PER_BIT, n_samp);
            bad = 1'b0;
            for (int k = 0; k < n_samp && k < len * CLKS_PER_BIT && !bad; k++) begin
                assert (line_s[k] == bits[k / CLKS_PER_BIT]) else begin
                    report_mismatch($sformatf("tx bit %0d", k / CLKS_PER_BIT),
                                    bits[k / CLKS_PER_BIT], line_s[k]);
                    bad = 1'b1;
                end
            end
        end
        if (rot_check && last_client >= 0) begin
            assert (client == (last_client + 1) % NUM_CLIENTS)
                else report_mismatch("client index", (last_client + 1) % NUM_CLIENTS, client);
        end
        last_client = client;
    endtask

    // serial line monitor, frame ends where frame_done is seen
    initial begin
        forever begin
            @(negedge tx);
            n_samp = 0;
            while (n_samp < MAX_SAMPLES && (n_samp == 0 || !frame_done)) begin
                @(negedge clk);
                line_s[n_samp] = tx;
                n_samp++;
                assert (busy === 1'b1) else begin
                    $display("busy was low at %0t ns while a frame was on the line", $time);
                    errors++;
                end
            end
            check_frame();
        end
    end

    always @(negedge clk) begin
        if (frame_done) begin
            done_cnt++;
        end
    end

    initial begin
        #(TOTAL_FRAMES * 13 * CLKS_PER_BIT * CLK_PERIOD + 5000);
        $display("timeout: only %0d of %0d frames were received on the line",
                 rx_count, push_count);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        int e0;
        int d0;
        tx_frame_t f;
        $timeformat(-9, 0, "", 0);
        client_valid = '0;
        client_frame = '0;
        reset        = 1'b1;
        rot_check    = 1'b0;
        last_client  = -1;
        full_seen    = '0;
        repeat (8) @(negedge clk);
        reset = 1'b0;

        e0 = errors; // idle line after reset
        for (int i = 0; i < 16; i++) begin
            assert (tx === 1'b1 && busy === 1'b0 && frame_done === 1'b0 && client_ready === '1)
                else begin
                    $display("line or ready flags not idle at %0t ns after reset", $time);
                    errors++;
                end
            @(negedge clk);
        end
        end_test("idle_after_reset", e0);

        e0 = errors;
        d0 = done_cnt;
        f.data     = 8'h35;
        f.two_stop = 1'b0;
        push_frame(0, f);
        wait_drain();
        assert (done_cnt - d0 == 1) else report_mismatch("frame_done pulses", 1, done_cnt - d0);
        end_test("single_frame", e0);

        e0 = errors;
        for (int i = 0; i < 4; i++) begin
            f.data     = 8'h80 | 8'($random(seed) & 32'h3f);
            f.two_stop = (i != 3);  // last one shows a start right after two stops
            push_frame(2, f);
        end
        wait_drain();
        end_test("two_stop_bits", e0);

        e0 = errors;
        rot_check   = 1'b1;
        last_client = -1;
        fork
            push_burst(0, 8);
            push_burst(1, 8);
            push_burst(2, 8);
            push_burst(3, 8);
        join
        wait_drain();
        rot_check = 1'b0;
        end_test("round_robin", e0);

        e0 = errors;
        full_seen = '0;
        push_burst(3, 10);
        wait_drain();
        assert (full_seen[3]) else begin
            $display("client_ready of client 3 never dropped while its fifo was full");
            errors++;
        end
        end_test("back_pressure", e0);

        for (int c = 0; c < NUM_CLIENTS; c++) begin
            assert (sent_q[c].size() == 0) else begin
                $display("client %0d still has %0d frames never seen on the line",
                         c, sent_q[c].size());
                errors++;
            end
        end

        $display("tests 5, failed %0d, frames pushed %0d, received %0d, errors %0d",
                 failed_tests, push_count, rx_count, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
uart_pkg.sv
tx_frame_fifo.sv
tx_rr_arbiter.sv
uart_tx_framer.sv
uart_tx_hub.sv
tb_uart_tx_hub.sv

// ==== Makefile ====
TOP = tb_uart_tx_hub

.PHONY: help test clean

help:
	@echo "make targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module $(TOP) -f all.f -Mdir obj_dir -o sim
	./obj_dir/sim | tee sim.log
	@grep -q "\*\*\* TEST PASSED \*\*\*" sim.log || (echo "simulation failed"; exit 1)

clean:
	rm -rf obj_dir sim.log
